// ==== project.f ====
rtl/mmu_pkg.sv
rtl/bus_pkg.sv
rtl/tlb.sv
rtl/addr_translate.sv
rtl/refill_fsm.sv
rtl/beat_counter.sv
rtl/line_buffer.sv
rtl/fetch_unit_top.sv
sim/fetch_unit_asserts.sv
sim/tb_fetch_unit.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - rtl/mmu_pkg.sv
  - rtl/bus_pkg.sv
  - rtl/tlb.sv
  - rtl/addr_translate.sv
  - rtl/refill_fsm.sv
  - rtl/beat_counter.sv
  - rtl/line_buffer.sv
  - rtl/fetch_unit_top.sv
  - target: simulation
    files:
      - sim/fetch_unit_asserts.sv
      - sim/tb_fetch_unit.sv

// ==== sim/tb_fetch_unit.sv ====
`timescale 1ns/1ns

module tb_fetch_unit import mmu_pkg::*, bus_pkg::*; ();

    localparam logic [31:0] MEM_PATTERN  = 32'h5a3c_96e1;
    localparam int          NUM_DIRECTED = 26;
    localparam int          NUM_RANDOM   = 200;
    localparam int          CYCLE_LIMIT  = 40 * (NUM_DIRECTED + NUM_RANDOM) + 100;

    typedef struct packed {
        fault_e      fault;
        line_t       line;
        logic [31:0] hs_mark;
        logic [31:0] rise_mark;
    } expect_t;

    logic        aclk;
    logic        arst_n;
    logic        req;
    logic [31:0] req_vaddr;
    logic        addr_ok;
    mmu_cfg_t    cfg;
    logic        tlb_we;
    logic [TLB_IDX_W-1:0] tlb_index;
    tlb_entry_t  tlb_entry;
    logic        data_ok;
    fetch_resp_t resp;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;

    tlb_entry_t  tlb_model [TLB_NUM];
    expect_t     expect_q [$];
    int unsigned error_count   = 0;
    int unsigned accept_count  = 0;
    int unsigned resp_count    = 0;
    int unsigned ar_hs_count   = 0;
    int unsigned ar_rise_count = 0;
    int unsigned cycle_count   = 0;
    logic        arvalid_prev  = 1'b0;

    fetch_unit_top fetch_unit_top_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .req       (req),
        .req_vaddr (req_vaddr),
        .addr_ok   (addr_ok),
        .cfg       (cfg),
        .tlb_we    (tlb_we),
        .tlb_index (tlb_index),
        .tlb_entry (tlb_entry),
        .data_ok   (data_ok),
        .resp      (resp),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    initial aclk = 1'b0;
    always #5 aclk = ~aclk;

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ MEM_PATTERN;
    endfunction

    // returns the expected fault and sets pa to the physical address
    function automatic fault_e ref_translate(input logic [31:0] va, input mmu_cfg_t c,
                                             output logic [31:0] pa);
        tlb_page_t sel;
        logic      hit;
        pa  = va;
        hit = 1'b0;
        sel = '0;
        if (!c.pg) return FAULT_NONE;
        if (c.dmw0.en && c.dmw0.plv_mask[c.plv] && va[31:29] == c.dmw0.vseg) begin
            pa = {c.dmw0.pseg, va[28:0]};
            return FAULT_NONE;
        end
        if (c.dmw1.en && c.dmw1.plv_mask[c.plv] && va[31:29] == c.dmw1.vseg) begin
            pa = {c.dmw1.pseg, va[28:0]};
            return FAULT_NONE;
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            if (!hit && tlb_model[i].e && tlb_model[i].vppn == va[31:13]
                    && (tlb_model[i].g || tlb_model[i].asid == c.asid)) begin
                hit = 1'b1;
                sel = va[12] ? tlb_model[i].odd : tlb_model[i].even;
            end
        end
        if (!hit) return FAULT_TLBR;
        if (!sel.v) return FAULT_PIF;
        if (c.plv > sel.plv) return FAULT_PPI;
        pa = {sel.ppn, va[11:0]};
        return FAULT_NONE;
    endfunction

    function automatic line_t ref_line(input logic [31:0] pa);
        line_t l;
        for (int k = 0; k < LINE_WORDS; k++) begin
            l[k] = mem_word({pa[31:4], 4'b0000} + 32'(4 * k));
        end
        return l;
    endfunction

    function automatic tlb_page_t make_page(input logic [PPN_W-1:0] ppn,
                                            input logic [1:0] plv, input logic v);
        tlb_page_t p;
        p.ppn = ppn;
        p.plv = plv;
        p.v   = v;
        return p;
    endfunction

    function automatic tlb_entry_t make_entry(input logic [VPPN_W-1:0] vppn,
                                              input logic [ASID_W-1:0] asid, input logic g,
                                              input tlb_page_t even, input tlb_page_t odd);
        tlb_entry_t en;
        en.e    = 1'b1;
        en.vppn = vppn;
        en.asid = asid;
        en.g    = g;
        en.even = even;
        en.odd  = odd;
        return en;
    endfunction

    task automatic wait_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic write_tlb(input int idx, input tlb_entry_t entry);
        wait_cycle();
        tlb_we    = 1'b1;
        tlb_index = TLB_IDX_W'(idx);
        tlb_entry = entry;
        wait_cycle();
        tlb_we         = 1'b0;
        tlb_model[idx] = entry;
    endtask

    // hold req until the unit takes it
    task automatic issue_request(input logic [31:0] va);
        wait_cycle();
        req       = 1'b1;
        req_vaddr = va;
        do begin
            @(negedge aclk);
        end while (!addr_ok);
        wait_cycle();
        req = 1'b0;
    endtask

    task automatic wait_all_done();
        while (resp_count != accept_count) wait_cycle();
    endtask

    task automatic run_fetch(input logic [31:0] va);
        issue_request(va);
        wait_all_done();
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            error_count++;
            $display("Error at %0t: %s expected 0 got %b", $time, name, value);
        end
    endtask

    // a line fill is one INCR burst of four word beats with id 0
    task automatic check_ar_fields();
        if (ar.id !== 4'd0) begin
            error_count++;
            $display("Error at %0t: ar.id expected 0 got %0d", $time, ar.id);
        end
        if (ar.len !== 8'd3) begin
            error_count++;
            $display("Error at %0t: ar.len expected 3 got %0d", $time, ar.len);
        end
        if (ar.size !== 3'd2) begin
            error_count++;
            $display("Error at %0t: ar.size expected 2 got %0d", $time, ar.size);
        end
        if (ar.burst !== 2'd1) begin
            error_count++;
            $display("Error at %0t: ar.burst expected 1 got %0d", $time, ar.burst);
        end
    endtask

    task automatic check_response(input expect_t exp);
        if (resp.fault !== exp.fault) begin
            error_count++;
            $display("Error at %0t: resp.fault expected %0d got %0d",
                     $time, exp.fault, resp.fault);
        end
        if (exp.fault == FAULT_NONE) begin
            for (int k = 0; k < LINE_WORDS; k++) begin
                if (resp.line[k] !== exp.line[k]) begin
                    error_count++;
                    $display("Error at %0t: resp.line[%0d] expected %h got %h",
                             $time, k, exp.line[k], resp.line[k]);
                end
            end
            if (ar_hs_count != exp.hs_mark + 1) begin
                error_count++;
                $display("At %0t a translated request did not make exactly one AR handshake",
                         $time);
            end
        end else if (ar_hs_count != exp.hs_mark || ar_rise_count != exp.rise_mark) begin
            error_count++;
            $display("At %0t a faulting request raised arvalid on the read bus", $time);
        end
    endtask

    // response and bus event checks on the falling edge
    always @(negedge aclk) begin : response_checker
        expect_t     exp;
        logic [31:0] pa;
        if (arst_n) begin
            if (arvalid && !arvalid_prev) ar_rise_count++;
            if (arvalid && arready) ar_hs_count++;
            if (addr_ok) begin
                exp.fault     = ref_translate(req_vaddr, cfg, pa);
                exp.line      = ref_line(pa);
                exp.hs_mark   = ar_hs_count;
                exp.rise_mark = ar_rise_count;
                expect_q.push_back(exp);
                accept_count++;
            end
            if (data_ok) begin
                if (expect_q.size() == 0) begin
                    error_count++;
                    $display("At %0t data_ok fired with no request outstanding", $time);
                end else begin
                    exp = expect_q.pop_front();
                    check_response(exp);
                end
                resp_count++;
            end
        end
        arvalid_prev = arvalid;
    end

    // read-only memory on the AXI read channel
    initial begin : memory_responder
        logic [31:0] base;
        int          gap;
        logic        took;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        @(posedge arst_n);
        forever begin
            wait_cycle();
            if (arvalid) begin
                base = ar.addr;
                check_ar_fields();
                gap  = $urandom_range(3, 0);
                repeat (gap) wait_cycle();
                arready = 1'b1;
                wait_cycle();
                arready = 1'b0;
                for (int k = 0; k < LINE_WORDS; k++) begin
                    gap = $urandom_range(2, 0);
                    repeat (gap) wait_cycle();
                    rvalid = 1'b1;
                    r.data = mem_word(base + 32'(4 * k));
                    r.last = (k == LINE_WORDS - 1);
                    do begin
                        took = rready;
                        wait_cycle();
                    end while (!took);
                    rvalid = 1'b0;
                    r.last = 1'b0;
                end
            end
        end
    end

    always @(posedge aclk) begin : watchdog
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d responses received",
                     cycle_count, resp_count, NUM_DIRECTED + NUM_RANDOM);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int unsigned total_errors;
        void'($urandom(34));
        arst_n    = 1'b0;
        req       = 1'b0;
        req_vaddr = '0;
        cfg       = '0;
        tlb_we    = 1'b0;
        tlb_index = '0;
        tlb_entry = '0;
        for (int i = 0; i < TLB_NUM; i++) tlb_model[i] = '0;
        repeat (3) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        @(negedge aclk);
        expect_low("arvalid", arvalid);
        expect_low("rready", rready);
        expect_low("data_ok", data_ok);
        expect_low("addr_ok", addr_ok);

        // paging off
        repeat (10) run_fetch($urandom());

        write_tlb(0, make_entry(19'h40000, 10'd5, 1'b0, make_page(20'h12340, 2'd3, 1'b1),
                                make_page(20'h23450, 2'd3, 1'b1)));
        write_tlb(1, make_entry(19'h00010, 10'd7, 1'b1, make_page(20'h00abc, 2'd0, 1'b1),
                                make_page(20'h00def, 2'd3, 1'b1)));
        write_tlb(2, make_entry(19'h00020, 10'd9, 1'b0, make_page(20'h03030, 2'd3, 1'b1),
                                make_page(20'h04040, 2'd3, 1'b1)));
        write_tlb(3, make_entry(19'h00030, 10'd5, 1'b0, make_page(20'h05050, 2'd3, 1'b0),
                                make_page(20'h06060, 2'd0, 1'b1)));
        write_tlb(4, make_entry(19'h00050, 10'd5, 1'b0, make_page(20'h11111, 2'd3, 1'b1),
                                make_page(20'h11112, 2'd3, 1'b1)));
        write_tlb(5, make_entry(19'h00050, 10'd5, 1'b0, make_page(20'h22222, 2'd3, 1'b1),
                                make_page(20'h22223, 2'd3, 1'b1)));

        // TLB only with windows off
        cfg.pg   = 1'b1;
        cfg.plv  = 2'd0;
        cfg.asid = 10'd5;
        run_fetch(32'h8000_0abc);
        run_fetch(32'h8000_1abc);
        run_fetch(32'h0002_0010);
        run_fetch(32'h0002_1ff0);
        run_fetch(32'h000a_0040);

        run_fetch(32'h0004_0100);
        run_fetch(32'h0006_0100);
        cfg.plv = 2'd3;
        run_fetch(32'h0006_1100);
        run_fetch(32'h0002_1000);

        // direct-mapped windows
        cfg.plv  = 2'd0;
        cfg.dmw0 = '{en: 1'b1, plv_mask: 4'b0001, vseg: 3'h4, pseg: 3'h0};
        cfg.dmw1 = '{en: 1'b1, plv_mask: 4'b1001, vseg: 3'h5, pseg: 3'h1};
        rnd = $urandom();
        run_fetch({3'h4, rnd[28:0]});
        rnd = $urandom();
        run_fetch({3'h5, rnd[28:0]});
        cfg.plv = 2'd3;
        run_fetch(32'h8000_0abc);
        rnd = $urandom();
        run_fetch({3'h5, rnd[28:0]});
        cfg.plv     = 2'd0;
        cfg.dmw0.en = 1'b0;
        run_fetch(32'h8000_1abc);

        // rewritten entries take effect
        write_tlb(0, make_entry(19'h40000, 10'd5, 1'b0, make_page(20'h0f0f0, 2'd3, 1'b1),
                                make_page(20'h0e0e0, 2'd3, 1'b1)));
        write_tlb(2, make_entry(19'h00020, 10'd9, 1'b1, make_page(20'h07070, 2'd3, 1'b1),
                                make_page(20'h08080, 2'd3, 1'b1)));
        run_fetch(32'h8000_0abc);
        run_fetch(32'h0004_0100);

        // mixed traffic under one cfg
        cfg.dmw0.en = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            repeat ($urandom_range(3, 0)) wait_cycle();
            rnd = $urandom();
            case ($urandom_range(5, 0))
                0: issue_request({3'h4, rnd[28:0]});
                1: issue_request({3'h5, rnd[28:0]});
                2: issue_request({19'h00010, rnd[12:0]});
                3: issue_request({19'h00050, rnd[12:0]});
                4: issue_request({19'h00030, rnd[12:0]});
                default: issue_request({1'b0, rnd[30:0]});
            endcase
        end
        wait_all_done();

        if (accept_count != NUM_DIRECTED + NUM_RANDOM || expect_q.size() != 0) begin
            error_count++;
            $display("Accepted %0d requests with %0d still pending, expected %0d and none",
                     accept_count, expect_q.size(), NUM_DIRECTED + NUM_RANDOM);
        end
        total_errors = error_count + fetch_unit_top_i.asserts_i.fail_count;
        $display("Done: %0d responses, %0d check errors, %0d assertion failures",
                 resp_count, error_count, fetch_unit_top_i.asserts_i.fail_count);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/fetch_unit_asserts.sv ====
`timescale 1ns/1ns

module fetch_unit_asserts import bus_pkg::*; (
    input logic    aclk,
    input logic    arst_n,
    input logic    req,
    input logic    addr_ok,
    input logic    data_ok,
    input axi_ar_t ar,
    input logic    arvalid,
    input logic    arready,
    input axi_r_t  r,
    input logic    rvalid,
    input logic    rready,
    input logic    last_beat
);

    int unsigned fail_count = 0;
    logic        pending;

    // a request is outstanding from addr_ok until its data_ok
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (addr_ok) begin
            pending <= 1'b1;
        end else if (data_ok) begin
            pending <= 1'b0;
        end
    end

    ar_held: assert property (@(posedge aclk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
    else begin
        fail_count++;
        $error("ar or arvalid changed before arready");
    end

    // rlast has to line up with the fourth beat
    last_aligned: assert property (@(posedge aclk) disable iff (!arst_n)
        rvalid && rready && r.last |-> last_beat)
    else begin
        fail_count++;
        $error("r.last arrived while last_beat was low");
    end

    data_ok_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        data_ok |=> !data_ok)
    else begin
        fail_count++;
        $error("data_ok held for more than one cycle");
    end

    addr_ok_with_req: assert property (@(posedge aclk) disable iff (!arst_n)
        addr_ok |-> req && !pending)
    else begin
        fail_count++;
        $error("addr_ok while req was low or a request was still outstanding");
    end

endmodule

bind fetch_unit_top fetch_unit_asserts asserts_i (.*);

// ==== rtl/fetch_unit_top.sv ====
`timescale 1ns/1ns

module fetch_unit_top import mmu_pkg::*, bus_pkg::*; (
    input  logic                 aclk,
    input  logic                 arst_n,
    // fetch port
    input  logic                 req,
    input  logic [31:0]          req_vaddr,
    output logic                 addr_ok,
    input  mmu_cfg_t             cfg,
    input  logic                 tlb_we,
    input  logic [TLB_IDX_W-1:0] tlb_index,
    input  tlb_entry_t           tlb_entry,
    output logic                 data_ok,
    output fetch_resp_t          resp,
    // axi read
    output axi_ar_t              ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  axi_r_t               r,
    input  logic                 rvalid,
    output logic                 rready
);

    trans_t            trans;
    logic              capture;
    logic              lookup;
    logic              beat;
    logic              start;
    logic [BEAT_W-1:0] beat_idx;
    logic              last_beat;
    line_t             line_data;

    addr_translate u_addr_translate (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .capture   (capture),
        .lookup    (lookup),
        .vaddr     (req_vaddr),
        .cfg       (cfg),
        .tlb_we    (tlb_we),
        .tlb_index (tlb_index),
        .tlb_entry (tlb_entry),
        .result    (trans)
    );

    refill_fsm u_refill_fsm (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .req       (req),
        .addr_ok   (addr_ok),
        .result    (trans),
        .capture   (capture),
        .lookup    (lookup),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .rready    (rready),
        .beat      (beat),
        .start     (start),
        .last_beat (last_beat),
        .data_ok   (data_ok)
    );

    beat_counter u_beat_counter (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .start     (start),
        .beat      (beat),
        .beat_idx  (beat_idx),
        .last_beat (last_beat)
    );

    line_buffer u_line_buffer (
        .aclk     (aclk),
        .beat     (beat),
        .beat_idx (beat_idx),
        .rdata    (r.data),
        .line     (line_data)
    );

    assign resp.line  = line_data;
    assign resp.fault = trans.fault;

endmodule

// ==== rtl/line_buffer.sv ====
`timescale 1ns/1ns

module line_buffer import bus_pkg::*; (
    input  logic              aclk,
    input  logic              beat,
    input  logic [BEAT_W-1:0] beat_idx,
    input  logic [31:0]       rdata,
    output line_t             line
);

    line_t line_q;

    // word k sits at bits 32k+31..32k
    always_ff @(posedge aclk) begin
        if (beat) begin
            line_q[beat_idx] <= rdata;
        end
    end

    assign line = line_q;

endmodule

// ==== rtl/beat_counter.sv ====
`timescale 1ns/1ns

module beat_counter import bus_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              start,
    input  logic              beat,
    output logic [BEAT_W-1:0] beat_idx,
    output logic              last_beat
);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            beat_idx <= '0;
        end else if (start) begin
            beat_idx <= '0;
        end else if (beat) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

    // high while the final word of the line is expected
    assign last_beat = (beat_idx == BEAT_W'(LINE_WORDS - 1));

endmodule

// ==== rtl/refill_fsm.sv ====
`timescale 1ns/1ns

module refill_fsm import mmu_pkg::*, bus_pkg::*; (
    input  logic    aclk,
    input  logic    arst_n,
    input  logic    req,
    output logic    addr_ok,
    input  trans_t  result,
    output logic    capture,
    output logic    lookup,
    output axi_ar_t ar,
    output logic    arvalid,
    input  logic    arready,
    input  logic    rvalid,
    output logic    rready,
    output logic    beat,
    output logic    start,
    input  logic    last_beat,
    output logic    data_ok
);

    refill_state_e state;
    refill_state_e state_next;
    logic          faulted;

    assign faulted = (result.fault != FAULT_NONE);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:    if (req) state_next = LOOKUP;
            LOOKUP:  state_next = ADDR;
            // a faulting translation completes here without a bus read
            ADDR: begin
                if (faulted) begin
                    state_next = IDLE;
                end else if (arready) begin
                    state_next = DATA;
                end
            end
            DATA:    if (beat && last_beat) state_next = DONE;
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign addr_ok = (state == IDLE) && req;
    assign capture = addr_ok;
    assign lookup  = (state == LOOKUP);

    // line-aligned burst address
    assign ar.id    = 4'd0;
    assign ar.addr  = {result.paddr[31:4], 4'b0000};
    assign ar.len   = AXI_LEN;
    assign ar.size  = AXI_SIZE_WORD;
    assign ar.burst = AXI_BURST_INCR;

    assign arvalid = (state == ADDR) && !faulted;
    assign start   = arvalid && arready;

    assign rready = (state == DATA);
    assign beat   = rvalid && rready;

    assign data_ok = (state == DONE) || ((state == ADDR) && faulted);

endmodule

// ==== rtl/addr_translate.sv ====
`timescale 1ns/1ns

module addr_translate import mmu_pkg::*; (
    input  logic                 aclk,
    input  logic                 arst_n,
    input  logic                 capture,
    input  logic                 lookup,
    input  logic [31:0]          vaddr,
    input  mmu_cfg_t             cfg,
    input  logic                 tlb_we,
    input  logic [TLB_IDX_W-1:0] tlb_index,
    input  tlb_entry_t           tlb_entry,
    output trans_t               result
);

    logic [31:0] vaddr_q;
    logic        tlb_found;
    tlb_page_t   tlb_page;
    trans_t      trans_next;

    function automatic logic dmw_hit(input dmw_t w, input logic [1:0] plv,
                                     input logic [2:0] seg);
        return w.en && w.plv_mask[plv] && (seg == w.vseg);
    endfunction

    always_ff @(posedge aclk) begin
        if (capture) begin
            vaddr_q <= vaddr;
        end
    end

    tlb u_tlb (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .we      (tlb_we),
        .w_index (tlb_index),
        .w_entry (tlb_entry),
        .vaddr   (vaddr_q),
        .asid    (cfg.asid),
        .found   (tlb_found),
        .page    (tlb_page)
    );

    // direct, then dmw0, dmw1, then the TLB
    always_comb begin
        trans_next.paddr = vaddr_q;
        trans_next.fault = FAULT_NONE;
        if (cfg.pg) begin
            if (dmw_hit(cfg.dmw0, cfg.plv, vaddr_q[31:29])) begin
                trans_next.paddr = {cfg.dmw0.pseg, vaddr_q[28:0]};
            end else if (dmw_hit(cfg.dmw1, cfg.plv, vaddr_q[31:29])) begin
                trans_next.paddr = {cfg.dmw1.pseg, vaddr_q[28:0]};
            end else if (!tlb_found) begin
                trans_next.fault = FAULT_TLBR;
            end else if (!tlb_page.v) begin
                trans_next.fault = FAULT_PIF;
            end else if (cfg.plv > tlb_page.plv) begin
                trans_next.fault = FAULT_PPI;
            end else begin
                trans_next.paddr = {tlb_page.ppn, vaddr_q[11:0]};
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (lookup) begin
            result <= trans_next;
        end
    end

endmodule

// ==== rtl/tlb.sv ====
`timescale 1ns/1ns

module tlb import mmu_pkg::*; (
    input  logic                 aclk,
    input  logic                 arst_n,
    input  logic                 we,
    input  logic [TLB_IDX_W-1:0] w_index,
    input  tlb_entry_t           w_entry,
    input  logic [31:0]          vaddr,
    input  logic [ASID_W-1:0]    asid,
    output logic                 found,
    output tlb_page_t            page
);

    tlb_entry_t           entries [TLB_NUM];
    logic [TLB_NUM-1:0]   valid;
    logic [TLB_NUM-1:0]   match;
    logic [TLB_IDX_W-1:0] hit_idx;
    tlb_entry_t           hit_entry;

    // e bits, cleared on reset
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (we) begin
            valid[w_index] <= w_entry.e;
        end
    end

    always_ff @(posedge aclk) begin
        if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            match[i] = valid[i]
                    && (entries[i].vppn == vaddr[31:13])
                    && (entries[i].g || (entries[i].asid == asid));
        end
    end

    // lowest matching index wins
    always_comb begin
        found   = 1'b0;
        hit_idx = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                found   = 1'b1;
                hit_idx = TLB_IDX_W'(i);
            end
        end
    end

    assign hit_entry = entries[hit_idx];

    // va bit 12 selects the odd page
    assign page = vaddr[12] ? hit_entry.odd : hit_entry.even;

endmodule

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

    localparam int LINE_WORDS = 4;
    localparam int BEAT_W     = 2;

    // INCR burst of four 32-bit beats
    localparam logic [7:0] AXI_LEN        = 8'd3;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    typedef struct packed {
        line_t           line;
        mmu_pkg::fault_e fault;
    } fetch_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ADDR,
        DATA,
        DONE
    } refill_state_e;

endpackage

// ==== rtl/mmu_pkg.sv ====
package mmu_pkg;

    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;
    localparam int VPPN_W    = 19;
    localparam int PPN_W     = 20;
    localparam int ASID_W    = 10;

    // one 4 KB half of a page pair
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         even;
        tlb_page_t         odd;
    } tlb_entry_t;

    // plv_mask has one bit per privilege level
    typedef struct packed {
        logic       en;
        logic [3:0] plv_mask;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        logic              pg;
        logic [1:0]        plv;
        logic [ASID_W-1:0] asid;
        dmw_t              dmw0;
        dmw_t              dmw1;
    } mmu_cfg_t;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_TLBR,
        FAULT_PIF,
        FAULT_PPI
    } fault_e;

    typedef struct packed {
        logic [31:0] paddr;
        fault_e      fault;
    } trans_t;

endpackage
